// File: source/mux_pkg.sv
// sizes, word structs, port vector type and the one-hot to index encoder
`default_nettype none

package mux_pkg;

	// port count and index width
	localparam int NUM_PORTS = 4;
	localparam int PORT_IDX_W = 2;

	// per-port queue sizing
	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
	// count runs 0..QUEUE_DEPTH so needs one more bit than the pointers
	localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

	localparam int DATA_W = 16;

	// payload held in each port queue
	typedef struct packed {
		logic [DATA_W-1:0] data;
	} in_word_t;

	// registered output word with its source port
	typedef struct packed {
		logic [PORT_IDX_W-1:0] port;
		logic [DATA_W-1:0] data;
	} out_word_t;

	// one bit per port
	typedef logic [NUM_PORTS-1:0] port_vec_t;

	// index of the set bit in a one-hot vector, zero when none is set
	function automatic logic [PORT_IDX_W-1:0] onehot_to_idx(input port_vec_t vec);
		logic [PORT_IDX_W-1:0] idx;
		idx = '0;
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (vec[i]) begin
				idx = idx | PORT_IDX_W'(i);
			end
		end
		return idx;
	endfunction

endpackage

`default_nettype wire

// File: source/port_queue.sv
// port_queue module, a small circular FIFO for one input port
`default_nettype none

module port_queue (
	input logic clk,
	input logic reset,
	input logic push,
	input mux_pkg::in_word_t push_word,
	input logic pop,
	output mux_pkg::in_word_t head_word,
	output logic not_empty,
	output logic full
);

	// word storage
	mux_pkg::in_word_t mem [mux_pkg::QUEUE_DEPTH];

	logic [mux_pkg::QUEUE_PTR_W-1:0] wr_ptr;
	logic [mux_pkg::QUEUE_PTR_W-1:0] rd_ptr;
	logic [mux_pkg::QUEUE_CNT_W-1:0] count;

	// write side
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_word;
		end
	end

	// pointers wrap on their own since depth is a power of two
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// occupancy
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else begin
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// head is read straight from the array, valid one cycle after the push
	assign head_word = mem[rd_ptr];
	assign not_empty = (count != '0);
	assign full = (count == mux_pkg::QUEUE_CNT_W'(mux_pkg::QUEUE_DEPTH));

	// sender must honour full
	assert property (@(posedge clk) disable iff (reset)
		push |-> !full)
	else $error("push into full queue");

	// arbiter only grants a queue that requested
	assert property (@(posedge clk) disable iff (reset)
		pop |-> not_empty)
	else $error("pop from empty queue");

endmodule

`default_nettype wire

// File: source/rr_arbiter.sv
// rr_arbiter module, round-robin scheduler over the queue requests with stall
`default_nettype none

module rr_arbiter (
	input logic clk,
	input logic reset,
	input mux_pkg::port_vec_t req,
	input logic stall,
	output mux_pkg::port_vec_t grant
);

	// most recently granted port
	logic [mux_pkg::PORT_IDX_W-1:0] prio_ptr;

	// ports strictly above the pointer
	mux_pkg::port_vec_t prio_mask;
	mux_pkg::port_vec_t masked_req;
	mux_pkg::port_vec_t grant_hi;
	mux_pkg::port_vec_t grant_wrap;
	mux_pkg::port_vec_t grant_raw;

	// lowest set bit of a vector
	function automatic mux_pkg::port_vec_t lowest_bit(input mux_pkg::port_vec_t vec);
		mux_pkg::port_vec_t neg;
		neg = ~vec + 1'b1;
		return vec & neg;
	endfunction

	// rotated priority mask built from the pointer
	always_comb begin
		for (int i = 0; i < mux_pkg::NUM_PORTS; i++) begin
			prio_mask[i] = (i > int'(prio_ptr));
		end
	end

	assign masked_req = req & prio_mask;

	// first request after the pointer
	assign grant_hi = lowest_bit(masked_req);

	// nothing above the pointer, wrap round to port 0
	assign grant_wrap = lowest_bit(req);

	always_comb begin
		if (masked_req != '0) begin
			grant_raw = grant_hi;
		end else begin
			grant_raw = grant_wrap;
		end
	end

	// stall freezes scheduling, nothing else in the design looks at it
	assign grant = stall ? '0 : grant_raw;

	// pointer follows each grant, starts at the last port so port 0 leads
	always_ff @(posedge clk) begin
		if (reset) begin
			prio_ptr <= mux_pkg::PORT_IDX_W'(mux_pkg::NUM_PORTS - 1);
		end else if (grant != '0) begin
			prio_ptr <= mux_pkg::onehot_to_idx(grant);
		end
	end

	// at most one queue popped per cycle
	assert property (@(posedge clk) disable iff (reset)
		$onehot0(grant))
	else $error("grant is not one-hot");

	// never pop a queue that is empty
	assert property (@(posedge clk) disable iff (reset)
		(grant & ~req) == '0)
	else $error("grant outside of req");

endmodule

`default_nettype wire

// File: source/grant_mux.sv
// grant_mux module, picks the granted queue head and registers the output word
`default_nettype none

module grant_mux (
	input logic clk,
	input logic reset,
	input mux_pkg::port_vec_t grant,
	input mux_pkg::in_word_t head_word [mux_pkg::NUM_PORTS],
	output logic out_valid,
	output mux_pkg::out_word_t out_word
);

	logic [mux_pkg::DATA_W-1:0] sel_data;
	logic [mux_pkg::PORT_IDX_W-1:0] sel_port;
	logic any_grant;

	// and-or select, grant is one-hot or zero
	always_comb begin
		sel_data = '0;
		for (int i = 0; i < mux_pkg::NUM_PORTS; i++) begin
			sel_data = sel_data | (head_word[i].data & {mux_pkg::DATA_W{grant[i]}});
		end
	end

	assign sel_port = mux_pkg::onehot_to_idx(grant);
	assign any_grant = |grant;

	// valid pulse in the cycle after the pop
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= any_grant;
		end
	end

	// word only loads with a grant so it holds between pulses
	always_ff @(posedge clk) begin
		if (any_grant) begin
			out_word.port <= sel_port;
			out_word.data <= sel_data;
		end
	end

	// output is steady whenever no word was delivered
	assert property (@(posedge clk) disable iff (reset)
		(!out_valid && !$isunknown($past(out_word))) |-> $stable(out_word))
	else $error("out_word changed without out_valid");

endmodule

`default_nettype wire

// File: source/port_mux_top.sv
// port_mux_top module, four port queues feeding a round-robin arbiter and grant stage
`default_nettype none

module port_mux_top (
	input logic clk,
	input logic reset,
	input mux_pkg::port_vec_t push,
	input mux_pkg::in_word_t push_word [mux_pkg::NUM_PORTS],
	input logic stall,
	output mux_pkg::port_vec_t full,
	output logic out_valid,
	output mux_pkg::out_word_t out_word
);

	// queue not-empty flags are the arbiter requests
	mux_pkg::port_vec_t req;

	// one-hot grant, also the pop of each queue
	mux_pkg::port_vec_t grant;

	mux_pkg::in_word_t head_word [mux_pkg::NUM_PORTS];

	for (genvar i = 0; i < mux_pkg::NUM_PORTS; i++) begin : g_port
		port_queue i_port_queue (
			.clk(clk),
			.reset(reset),
			.push(push[i]),
			.push_word(push_word[i]),
			.pop(grant[i]),
			.head_word(head_word[i]),
			.not_empty(req[i]),
			.full(full[i])
		);
	end

	// stall only reaches the arbiter
	rr_arbiter i_rr_arbiter (
		.clk(clk),
		.reset(reset),
		.req(req),
		.stall(stall),
		.grant(grant)
	);

	grant_mux i_grant_mux (
		.clk(clk),
		.reset(reset),
		.grant(grant),
		.head_word(head_word),
		.out_valid(out_valid),
		.out_word(out_word)
	);

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
// tb_clock_gen module, testbench clock and power-on reset
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	localparam int PERIOD = 100;
	localparam int RESET_CYCLES = 8;

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// release on a falling edge so the first functional edge is clean
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: sim/port_mux_tb.sv
// port_mux_tb module, table-driven testbench with reference model, check task and watchdog
`default_nettype none

module port_mux_tb;

	localparam int CLK_PERIOD = 100;
	localparam int SEED = 4343;
	localparam int RANDOM_ROWS = 100;
	localparam int DRAIN_ROWS = 20;

	// one clock cycle of stimulus
	typedef struct packed {
		mux_pkg::port_vec_t push;
		logic [mux_pkg::NUM_PORTS-1:0][mux_pkg::DATA_W-1:0] data;
		logic stall;
	} row_t;

	logic clk;
	logic reset;
	mux_pkg::port_vec_t push;
	mux_pkg::in_word_t push_word [mux_pkg::NUM_PORTS];
	logic stall;
	mux_pkg::port_vec_t full;
	logic out_valid;
	mux_pkg::out_word_t out_word;

	row_t rows [$];
	int word_seq;
	logic table_ready;

	// reference model state
	logic [mux_pkg::DATA_W-1:0] model_mem [mux_pkg::NUM_PORTS][mux_pkg::QUEUE_DEPTH];
	int model_rd [mux_pkg::NUM_PORTS];
	int model_cnt [mux_pkg::NUM_PORTS];
	int model_ptr;

	// predicted outputs after the next rising edge
	logic exp_valid;
	mux_pkg::out_word_t exp_word;
	mux_pkg::port_vec_t exp_full;

	tb_clock_gen i_tb_clock_gen (
		.clk(clk),
		.reset(reset)
	);

	port_mux_top i_port_mux_top (
		.clk(clk),
		.reset(reset),
		.push(push),
		.push_word(push_word),
		.stall(stall),
		.full(full),
		.out_valid(out_valid),
		.out_word(out_word)
	);

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("** Error at time %0t: %s is 0x%0h, expected 0x%0h",
				$time, name, actual, expected);
			$display("Test failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// data words carry the port in the top nibble and a row count below
	task automatic add_row(input mux_pkg::port_vec_t push_vec, input logic stall_lvl);
		row_t row;
		row.push = push_vec;
		row.stall = stall_lvl;
		for (int p = 0; p < mux_pkg::NUM_PORTS; p++) begin
			row.data[p] = mux_pkg::DATA_W'((p << 12) | (word_seq & 'hfff));
		end
		word_seq++;
		rows.push_back(row);
	endtask

	task automatic add_random_row();
		row_t row;
		row.push = mux_pkg::port_vec_t'($urandom_range(0, 15));
		// roughly one cycle in ten is stalled
		row.stall = ($urandom_range(0, 9) == 0);
		for (int p = 0; p < mux_pkg::NUM_PORTS; p++) begin
			row.data[p] = mux_pkg::DATA_W'($urandom);
		end
		rows.push_back(row);
	endtask

	task automatic build_table();
		// single word on port 2
		add_row(4'b0100, 1'b0);
		repeat (2) add_row(4'b0000, 1'b0);
		// ports 1 and 3 after port 2, then port 0 joins late
		add_row(4'b1010, 1'b0);
		add_row(4'b1010, 1'b0);
		add_row(4'b0001, 1'b0);
		repeat (6) add_row(4'b0000, 1'b0);
		// leave the pointer on port 3
		add_row(4'b1000, 1'b0);
		repeat (2) add_row(4'b0000, 1'b0);
		// fill every queue while stalled
		repeat (4) add_row(4'b1111, 1'b1);
		add_row(4'b0000, 1'b1);
		// release, words leave in port order
		repeat (6) add_row(4'b0000, 1'b0);
		// stall mid drain, refill ports 0 and 1
		repeat (2) add_row(4'b0011, 1'b1);
		repeat (2) add_row(4'b0000, 1'b1);
		repeat (DRAIN_ROWS) add_row(4'b0000, 1'b0);
		// random traffic
		repeat (RANDOM_ROWS) add_random_row();
		repeat (DRAIN_ROWS) add_row(4'b0000, 1'b0);
	endtask

	task automatic reset_model();
		for (int p = 0; p < mux_pkg::NUM_PORTS; p++) begin
			model_rd[p] = 0;
			model_cnt[p] = 0;
		end
		model_ptr = mux_pkg::NUM_PORTS - 1;
		exp_valid = 1'b0;
		exp_word = '0;
		exp_full = '0;
	endtask

	function automatic int words_left();
		int total;
		total = 0;
		for (int p = 0; p < mux_pkg::NUM_PORTS; p++) begin
			total += model_cnt[p];
		end
		return total;
	endfunction

	// one rising edge of the model, pop before push
	task automatic predict_edge(input mux_pkg::port_vec_t push_vec, input row_t row);
		int grant_idx;
		int cand;
		int slot;
		grant_idx = -1;
		if (!row.stall) begin
			for (int k = 1; k <= mux_pkg::NUM_PORTS; k++) begin
				cand = (model_ptr + k) % mux_pkg::NUM_PORTS;
				if (grant_idx < 0 && model_cnt[cand] != 0) begin
					grant_idx = cand;
				end
			end
		end
		exp_valid = (grant_idx >= 0);
		if (exp_valid) begin
			exp_word.port = mux_pkg::PORT_IDX_W'(grant_idx);
			exp_word.data = model_mem[grant_idx][model_rd[grant_idx]];
			model_rd[grant_idx] = (model_rd[grant_idx] + 1) % mux_pkg::QUEUE_DEPTH;
			model_cnt[grant_idx]--;
			model_ptr = grant_idx;
		end
		for (int p = 0; p < mux_pkg::NUM_PORTS; p++) begin
			if (push_vec[p]) begin
				slot = (model_rd[p] + model_cnt[p]) % mux_pkg::QUEUE_DEPTH;
				model_mem[p][slot] = row.data[p];
				model_cnt[p]++;
			end
		end
		for (int p = 0; p < mux_pkg::NUM_PORTS; p++) begin
			exp_full[p] = (model_cnt[p] == mux_pkg::QUEUE_DEPTH);
		end
	endtask

	task automatic compare_outputs();
		check_value("out_valid", out_valid, exp_valid);
		check_value("full", full, exp_full);
		if (exp_valid) begin
			check_value("out_word.port", out_word.port, exp_word.port);
			check_value("out_word.data", out_word.data, exp_word.data);
		end
	endtask

	// drive one row, never into a queue the model sees as full
	task automatic apply_row(input row_t row);
		mux_pkg::port_vec_t push_vec;
		push_vec = row.push & ~exp_full;
		push = push_vec;
		stall = row.stall;
		for (int p = 0; p < mux_pkg::NUM_PORTS; p++) begin
			push_word[p].data = row.data[p];
		end
		predict_edge(push_vec, row);
	endtask

	initial begin
		push = '0;
		stall = 1'b0;
		for (int p = 0; p < mux_pkg::NUM_PORTS; p++) begin
			push_word[p] = '0;
		end
		table_ready = 1'b0;
		word_seq = 0;
		void'($urandom(SEED));
		build_table();
		table_ready = 1'b1;
		reset_model();

		@(negedge reset);
		for (int r = 0; r < rows.size(); r++) begin
			compare_outputs();
			apply_row(rows[r]);
			@(negedge clk);
		end
		compare_outputs();

		if (words_left() == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("%0d words were never delivered after the drain rows", words_left());
			$display("Test failed");
			$fatal(1, "undelivered words");
		end
	end

	// whole table plus margin for reset and drain
	initial begin
		wait (table_ready === 1'b1);
		#((rows.size() + 20) * CLK_PERIOD);
		$display("the run did not finish within the expected number of cycles");
		$display("Test failed");
		$fatal(1, "watchdog timeout");
	end

endmodule

`default_nettype wire

// File: compile.f
source/mux_pkg.sv
source/port_queue.sv
source/rr_arbiter.sv
source/grant_mux.sv
source/port_mux_top.sv
sim/tb_clock_gen.sv
sim/port_mux_tb.sv

// File: Bender.yml
package:
  name: port_mux

sources:
  - files:
      - source/mux_pkg.sv
      - source/port_queue.sv
      - source/rr_arbiter.sv
      - source/grant_mux.sv
      - source/port_mux_top.sv
  - target: test
    files:
      - sim/tb_clock_gen.sv
      - sim/port_mux_tb.sv
